// ==== source/acc_mgmt_defs.svh ====
`ifndef ACC_MGMT_DEFS_SVH
`define ACC_MGMT_DEFS_SVH

// memory word width.
`define ACC_DATA_W 32

// word address width.
`define ACC_ADDR_W 16

// request tag width; a tag names the issuing queue.
`define ACC_TAG_W 8

// number of copy channels in the accelerator.
`define ACC_NUM_CH 2

// width of a transfer length in words.
`define ACC_COUNT_W 16

// log2 of the arbiter input FIFO depth.
`define ACC_FIFO_DEPTH_BITS 3

// reads a channel may have in flight. The FIFOs keep this many entries free.
`define ACC_MAX_OUTSTANDING 4

`endif

// ==== source/acc_mgmt_pkg.sv ====
`include "acc_mgmt_defs.svh"

package acc_mgmt_pkg;

  typedef logic [`ACC_DATA_W-1:0]  data_t;
  typedef logic [`ACC_ADDR_W-1:0]  addr_t;
  typedef logic [`ACC_TAG_W-1:0]   tag_t;
  typedef logic [`ACC_COUNT_W-1:0] count_t;

  // read request as it travels through the read arbiter.
  typedef struct packed {
    addr_t addr;
    tag_t  tag;
  } rd_req_t;

  typedef struct packed {
    data_t data;
    addr_t addr;
    tag_t  tag;
  } wr_req_t;

  // configuration word of one copy channel.
  typedef struct packed {
    addr_t  src_base;
    addr_t  dst_base;
    count_t length;
    data_t  addend;
  } chan_conf_t;

  typedef enum logic [1:0] {
    IDLE,
    RUN,
    DRAIN,
    DONE
  } chan_state_t;

endpackage

// ==== source/req_fifo.sv ====
`timescale 1ns/1ps
`include "acc_mgmt_defs.svh"

module req_fifo #(
  parameter int WIDTH      = 24,
  parameter int DEPTH_BITS = `ACC_FIFO_DEPTH_BITS
) (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             push,
  input  logic [WIDTH-1:0] push_data,
  input  logic             pop,
  output logic [WIDTH-1:0] pop_data,
  output logic             empty,
  output logic             headroom
);

  localparam int DEPTH = 1 << DEPTH_BITS;

  logic [WIDTH-1:0]      mem [DEPTH];
  logic [DEPTH_BITS-1:0] wr_ptr;
  logic [DEPTH_BITS-1:0] rd_ptr;
  logic [DEPTH_BITS:0]   fill;
  logic                  do_pop;

  assign do_pop   = pop && !empty; // a pop on an empty FIFO is ignored.
  assign empty    = (fill == '0);
  assign pop_data = mem[rd_ptr];

  // the producer may push again while this many slots stay free.
  assign headroom = (int'(fill) <= DEPTH - `ACC_MAX_OUTSTANDING);

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= push_data;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      fill   <= '0;
    end else begin
      if (push) wr_ptr <= wr_ptr + 1'b1;
      if (do_pop) rd_ptr <= rd_ptr + 1'b1;
      case ({push, do_pop})
        2'b10:   fill <= fill + 1'b1;
        2'b01:   fill <= fill - 1'b1;
        default: fill <= fill;
      endcase
    end
  end

endmodule

// ==== source/req_arbiter.sv ====
`timescale 1ns/1ps
`include "acc_mgmt_defs.svh"

module req_arbiter #(
  parameter int DATA_WIDTH = 24,
  parameter int NUM_IN     = 2
) (
  input  logic                               clk,
  input  logic                               rst_n,
  input  logic [NUM_IN-1:0]                  in_en,
  input  logic [NUM_IN-1:0][DATA_WIDTH-1:0]  in_data,
  input  logic                               out_available,
  output logic [NUM_IN-1:0]                  in_available,
  output logic                               out_en,
  output logic [DATA_WIDTH-1:0]              out_data
);

  localparam int PTR_W = (NUM_IN > 1) ? $clog2(NUM_IN) : 1;

  logic [NUM_IN-1:0]                 fifo_empty;
  logic [NUM_IN-1:0]                 fifo_pop;
  logic [NUM_IN-1:0][DATA_WIDTH-1:0] fifo_data;
  logic [PTR_W-1:0]                  rr_ptr;
  logic [PTR_W-1:0]                  grant_idx;
  logic                              grant_found;

  for (genvar i = 0; i < NUM_IN; i++) begin : g_in
    req_fifo #(
      .WIDTH      (DATA_WIDTH),
      .DEPTH_BITS (`ACC_FIFO_DEPTH_BITS)
    ) i_req_fifo (
      .clk       (clk),
      .rst_n     (rst_n),
      .push      (in_en[i]),
      .push_data (in_data[i]),
      .pop       (fifo_pop[i]),
      .pop_data  (fifo_data[i]),
      .empty     (fifo_empty[i]),
      .headroom  (in_available[i])
    );

    assign fifo_pop[i] = out_en && (int'(grant_idx) == i);
  end

  // search starts at the pointer and wraps around once.
  always_comb begin
    int idx;
    grant_found = 1'b0;
    grant_idx   = '0;
    for (int i = 0; i < NUM_IN; i++) begin
      idx = (int'(rr_ptr) + i) % NUM_IN;
      if (!grant_found && !fifo_empty[idx]) begin
        grant_found = 1'b1;
        grant_idx   = PTR_W'(idx);
      end
    end
  end

  assign out_en   = grant_found && out_available; // held while the port is busy.
  assign out_data = fifo_data[grant_idx];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rr_ptr <= '0;
    end else if (out_en) begin
      if (int'(grant_idx) == NUM_IN - 1) begin
        rr_ptr <= '0;
      end else begin
        rr_ptr <= grant_idx + 1'b1;
      end
    end
  end

endmodule

// ==== source/copy_channel.sv ====
`timescale 1ns/1ps
`include "acc_mgmt_defs.svh"

module copy_channel (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     soft_rst,
  input  logic                     conf_load,
  input  acc_mgmt_pkg::chan_conf_t conf,
  input  logic                     start,
  input  logic                     rd_available,
  input  logic                     rd_resp_valid,
  input  acc_mgmt_pkg::data_t      rd_resp_data,
  input  logic                     wr_available,
  input  logic                     wr_resp_valid,
  output logic                     rd_en,
  output acc_mgmt_pkg::rd_req_t    rd_req,
  output logic                     wr_en,
  output acc_mgmt_pkg::wr_req_t    wr_req,
  output logic                     done
);

  localparam int OUT_W = $clog2(`ACC_MAX_OUTSTANDING) + 1;

  acc_mgmt_pkg::chan_state_t state;
  acc_mgmt_pkg::chan_conf_t  conf_q;
  acc_mgmt_pkg::count_t      rd_issued;
  acc_mgmt_pkg::count_t      wr_done;
  acc_mgmt_pkg::count_t      wr_done_nxt;
  acc_mgmt_pkg::addr_t       wr_addr;
  logic [OUT_W-1:0]          rd_outstanding;
  logic                      active;
  logic                      reads_left;
  logic                      last_read;

  always_ff @(posedge clk) begin
    if (conf_load) conf_q <= conf;
  end

  assign active     = (state == acc_mgmt_pkg::RUN) || (state == acc_mgmt_pkg::DRAIN);
  assign reads_left = (rd_issued != conf_q.length);
  assign done       = (state == acc_mgmt_pkg::DONE);

  // A read needs room for its own write later on, so both ports must have headroom.
  assign rd_en = (state == acc_mgmt_pkg::RUN) && reads_left && rd_available &&
                 wr_available && (int'(rd_outstanding) < `ACC_MAX_OUTSTANDING);
  assign last_read = rd_en && (rd_issued + 1'b1 == conf_q.length);

  assign rd_req.addr = conf_q.src_base + acc_mgmt_pkg::addr_t'(rd_issued);
  assign rd_req.tag  = '0; // the parent inserts the channel tag.

  // responses come back in order, so the write address just counts up.
  assign wr_en       = active && rd_resp_valid;
  assign wr_req.data = rd_resp_data + conf_q.addend;
  assign wr_req.addr = wr_addr;
  assign wr_req.tag  = '0;

  assign wr_done_nxt = wr_done + acc_mgmt_pkg::count_t'(active && wr_resp_valid);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state          <= acc_mgmt_pkg::IDLE;
      rd_issued      <= '0;
      rd_outstanding <= '0;
      wr_done        <= '0;
      wr_addr        <= '0;
    end else if (soft_rst) begin
      state          <= acc_mgmt_pkg::IDLE;
      rd_issued      <= '0;
      rd_outstanding <= '0;
      wr_done        <= '0;
      wr_addr        <= '0;
    end else begin
      if (rd_en) rd_issued <= rd_issued + 1'b1;
      if (wr_en) wr_addr <= wr_addr + 1'b1;
      wr_done <= wr_done_nxt;
      case ({rd_en, wr_en})
        2'b10:   rd_outstanding <= rd_outstanding + 1'b1;
        2'b01:   rd_outstanding <= rd_outstanding - 1'b1;
        default: rd_outstanding <= rd_outstanding;
      endcase

      case (state)
        acc_mgmt_pkg::IDLE, acc_mgmt_pkg::DONE: begin
          if (start) begin
            state          <= acc_mgmt_pkg::RUN;
            rd_issued      <= '0;
            rd_outstanding <= '0;
            wr_done        <= '0;
            wr_addr        <= conf_q.dst_base;
          end
        end
        acc_mgmt_pkg::RUN: begin
          if (last_read || !reads_left) state <= acc_mgmt_pkg::DRAIN;
        end
        acc_mgmt_pkg::DRAIN: begin
          if (wr_done_nxt == conf_q.length) state <= acc_mgmt_pkg::DONE;
        end
        default: state <= acc_mgmt_pkg::IDLE;
      endcase
    end
  end

endmodule

// ==== source/stream_accelerator.sv ====
`timescale 1ns/1ps
`include "acc_mgmt_defs.svh"

module stream_accelerator (
  input  logic                                     clk,
  input  logic                                     rst_n,
  input  logic [`ACC_NUM_CH-1:0]                   soft_rst,
  input  logic [`ACC_NUM_CH-1:0]                   start,
  input  logic [`ACC_NUM_CH-1:0]                   conf_valid,
  input  acc_mgmt_pkg::chan_conf_t                 conf,
  input  logic [`ACC_NUM_CH-1:0]                   rd_available,
  input  logic [`ACC_NUM_CH-1:0]                   wr_available,
  input  logic                                     rd_resp_valid,
  input  acc_mgmt_pkg::tag_t                       rd_resp_tag,
  input  acc_mgmt_pkg::data_t                      rd_resp_data,
  input  logic                                     wr_resp_valid,
  input  acc_mgmt_pkg::tag_t                       wr_resp_tag,
  output logic [`ACC_NUM_CH-1:0]                   rd_en,
  output acc_mgmt_pkg::rd_req_t [`ACC_NUM_CH-1:0]  rd_req,
  output logic [`ACC_NUM_CH-1:0]                   wr_en,
  output acc_mgmt_pkg::wr_req_t [`ACC_NUM_CH-1:0]  wr_req,
  output logic [`ACC_NUM_CH-1:0]                   done
);

  for (genvar i = 0; i < `ACC_NUM_CH; i++) begin : g_chan
    acc_mgmt_pkg::rd_req_t ch_rd_req;
    acc_mgmt_pkg::wr_req_t ch_wr_req;
    logic                  rd_hit;
    logic                  wr_hit;

    // a response belongs to the channel whose index matches its tag.
    assign rd_hit = rd_resp_valid && (rd_resp_tag == acc_mgmt_pkg::tag_t'(i));
    assign wr_hit = wr_resp_valid && (wr_resp_tag == acc_mgmt_pkg::tag_t'(i));

    copy_channel i_copy_channel (
      .clk           (clk),
      .rst_n         (rst_n),
      .soft_rst      (soft_rst[i]),
      .conf_load     (conf_valid[i]), // each channel captures its own word.
      .conf          (conf),
      .start         (start[i]),
      .rd_available  (rd_available[i]),
      .rd_resp_valid (rd_hit),
      .rd_resp_data  (rd_resp_data),
      .wr_available  (wr_available[i]),
      .wr_resp_valid (wr_hit),
      .rd_en         (rd_en[i]),
      .rd_req        (ch_rd_req),
      .wr_en         (wr_en[i]),
      .wr_req        (ch_wr_req),
      .done          (done[i])
    );

    assign rd_req[i] = '{addr: ch_rd_req.addr, tag: acc_mgmt_pkg::tag_t'(i)};
    assign wr_req[i] = '{data: ch_wr_req.data,
                         addr: ch_wr_req.addr,
                         tag:  acc_mgmt_pkg::tag_t'(i)};
  end

endmodule

// ==== source/acc_mgmt_top.sv ====
`timescale 1ns/1ps
`include "acc_mgmt_defs.svh"

module acc_mgmt_top (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic [`ACC_NUM_CH-1:0]   soft_rst,
  input  logic [`ACC_NUM_CH-1:0]   start,
  input  logic [`ACC_NUM_CH-1:0]   conf_valid,
  input  acc_mgmt_pkg::chan_conf_t conf,
  input  logic                     rd_available,
  input  logic                     rd_resp_valid,
  input  acc_mgmt_pkg::data_t      rd_resp_data,
  input  acc_mgmt_pkg::tag_t       rd_resp_tag,
  input  logic                     wr_available,
  input  logic                     wr_resp_valid,
  input  acc_mgmt_pkg::tag_t       wr_resp_tag,
  output logic                     rd_req_en,
  output acc_mgmt_pkg::rd_req_t    rd_req,
  output logic                     wr_req_en,
  output acc_mgmt_pkg::wr_req_t    wr_req,
  output logic [31:0]              info
);

  logic [`ACC_NUM_CH-1:0]                  acc_rd_en;
  logic [`ACC_NUM_CH-1:0]                  acc_wr_en;
  logic [`ACC_NUM_CH-1:0]                  acc_rd_available;
  logic [`ACC_NUM_CH-1:0]                  acc_wr_available;
  logic [`ACC_NUM_CH-1:0]                  acc_done;
  logic [`ACC_NUM_CH-1:0]                  done_q;
  acc_mgmt_pkg::rd_req_t [`ACC_NUM_CH-1:0] acc_rd_req;
  acc_mgmt_pkg::wr_req_t [`ACC_NUM_CH-1:0] acc_wr_req;
  logic                                    rd_arb_en;
  acc_mgmt_pkg::rd_req_t                   rd_arb_data;
  logic                                    wr_arb_en;
  acc_mgmt_pkg::wr_req_t                   wr_arb_data;

  stream_accelerator i_stream_accelerator (
    .clk           (clk),
    .rst_n         (rst_n),
    .soft_rst      (soft_rst),
    .start         (start),
    .conf_valid    (conf_valid),
    .conf          (conf),
    .rd_available  (acc_rd_available),
    .wr_available  (acc_wr_available),
    .rd_resp_valid (rd_resp_valid),
    .rd_resp_tag   (rd_resp_tag),
    .rd_resp_data  (rd_resp_data),
    .wr_resp_valid (wr_resp_valid),
    .wr_resp_tag   (wr_resp_tag),
    .rd_en         (acc_rd_en),
    .rd_req        (acc_rd_req),
    .wr_en         (acc_wr_en),
    .wr_req        (acc_wr_req),
    .done          (acc_done)
  );

  req_arbiter #(
    .DATA_WIDTH ($bits(acc_mgmt_pkg::rd_req_t)),
    .NUM_IN     (`ACC_NUM_CH)
  ) i_rd_arbiter (
    .clk           (clk),
    .rst_n         (rst_n),
    .in_en         (acc_rd_en),
    .in_data       (acc_rd_req),
    .out_available (rd_available),
    .in_available  (acc_rd_available),
    .out_en        (rd_arb_en),
    .out_data      (rd_arb_data)
  );

  req_arbiter #(
    .DATA_WIDTH ($bits(acc_mgmt_pkg::wr_req_t)),
    .NUM_IN     (`ACC_NUM_CH)
  ) i_wr_arbiter (
    .clk           (clk),
    .rst_n         (rst_n),
    .in_en         (acc_wr_en),
    .in_data       (acc_wr_req),
    .out_available (wr_available),
    .in_available  (acc_wr_available),
    .out_en        (wr_arb_en),
    .out_data      (wr_arb_data)
  );

  // The port strobes trail the arbiter grant by one cycle.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_req_en <= 1'b0;
      wr_req_en <= 1'b0;
      done_q    <= '0;
    end else begin
      rd_req_en <= rd_arb_en;
      wr_req_en <= wr_arb_en;
      done_q    <= acc_done;
    end
  end

  always_ff @(posedge clk) begin
    rd_req <= rd_arb_data;
    wr_req <= wr_arb_data;
  end

  always_comb begin
    info                        = '0;
    info[7:0]                   = 8'(`ACC_NUM_CH); // read queues.
    info[15:8]                  = 8'(`ACC_NUM_CH); // write queues.
    info[16 +: `ACC_NUM_CH]     = done_q;
  end

endmodule

// ==== testbench/tb_acc_mgmt.sv ====
`timescale 1ns/1ps
`include "acc_mgmt_defs.svh"

module tb_acc_mgmt;

  logic                                  clk;
  logic                                  rst_n;
  logic [`ACC_NUM_CH-1:0]                soft_rst;
  logic [`ACC_NUM_CH-1:0]                start;
  logic [`ACC_NUM_CH-1:0]                conf_valid;
  acc_mgmt_pkg::chan_conf_t              conf;
  logic                                  rd_available;
  logic                                  rd_resp_valid;
  acc_mgmt_pkg::data_t                   rd_resp_data;
  acc_mgmt_pkg::tag_t                    rd_resp_tag;
  logic                                  wr_available;
  logic                                  wr_resp_valid;
  acc_mgmt_pkg::tag_t                    wr_resp_tag;
  logic                                  rd_req_en;
  acc_mgmt_pkg::rd_req_t                 rd_req;
  logic                                  wr_req_en;
  acc_mgmt_pkg::wr_req_t                 wr_req;
  logic [31:0]                           info;

  logic [31:0] pat [0:63];    // source words, configurations and expected words.
  logic [31:0] mem [0:65535]; // memory image seen by both ports.
  logic [31:0] lfsr = 32'h5566_7a7a;
  logic        stress;
  int          cycle;
  int          errors;
  int          failures;
  int          quiet_mark;
  int          dst_lo [`ACC_NUM_CH];
  int          dst_len [`ACC_NUM_CH];
  int          reqs_seen [`ACC_NUM_CH];
  int          last_req [`ACC_NUM_CH];
  int          last_due [`ACC_NUM_CH];
  int          q_tag [$];
  int          q_due [$];
  logic [31:0] q_data [$];
  int          wr_q [$];

  acc_mgmt_top i_acc_mgmt_top (.*);

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  task automatic compare_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
    if (actual !== expected) begin
      errors++;
      $display("CHECK FAILED at %0t: %s expected %0h actual %0h", $time, name, expected, actual);
    end
  endtask

  // fibonacci LFSR with taps 32, 22, 2 and 1 that steps once per bit.
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] bits;
    logic        fb;
    bits = '0;
    for (int i = 0; i < n; i++) begin
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      bits = {bits[30:0], fb};
    end
    return bits;
  endfunction

  function automatic logic [31:0] fill_word(input int addr);
    return {addr[15:0], ~addr[15:0]};
  endfunction

  function automatic int pending_reads(input int tag);
    int n;
    n = 0;
    foreach (q_tag[i]) if (q_tag[i] == tag) n++;
    return n;
  endfunction

  always @(negedge clk) begin : mem_model
    int tag;
    int due;
    int pick;
    int in_range;
    cycle++;
    if (rst_n && rd_req_en) begin
      compare_value("rd_available before rd_req_en", 1, rd_available);
      tag = int'(rd_req.tag);
      if (tag >= `ACC_NUM_CH) begin
        failures++;
        $display("read request at %0t carries unknown tag %0d", $time, tag);
      end else begin
        due = cycle + 2 + int'(take_bits(2));
        if (due < last_due[tag]) due = last_due[tag]; // keeps per-tag order.
        last_due[tag] = due;
        q_tag.push_back(tag);
        q_due.push_back(due);
        q_data.push_back(mem[rd_req.addr]);
        reqs_seen[tag]++;
        last_req[tag] = cycle;
      end
    end
    if (rst_n && wr_req_en) begin
      compare_value("wr_available before wr_req_en", 1, wr_available);
      tag = int'(wr_req.tag);
      if (tag >= `ACC_NUM_CH) begin
        failures++;
        $display("write request at %0t carries unknown tag %0d", $time, tag);
      end else begin
        in_range = (int'(wr_req.addr) >= dst_lo[tag]) &&
                   (int'(wr_req.addr) < dst_lo[tag] + dst_len[tag]);
        compare_value("wr_req.addr in range of wr_req.tag", 1, in_range);
        mem[wr_req.addr] = wr_req.data;
        wr_q.push_back(tag);
        reqs_seen[tag]++;
        last_req[tag] = cycle;
      end
    end
    // the oldest due response goes first.
    pick = -1;
    foreach (q_due[i]) if (pick < 0 && q_due[i] <= cycle) pick = i;
    rd_resp_valid = (pick >= 0);
    if (pick >= 0) begin
      rd_resp_tag  = acc_mgmt_pkg::tag_t'(q_tag[pick]);
      rd_resp_data = q_data[pick];
      q_tag.delete(pick);
      q_due.delete(pick);
      q_data.delete(pick);
    end
    wr_resp_valid = (wr_q.size() > 0);
    if (wr_q.size() > 0) wr_resp_tag = acc_mgmt_pkg::tag_t'(wr_q.pop_front());
    rd_available = stress ? (take_bits(2) != 0) : 1'b1;
    wr_available = stress ? (take_bits(2) != 0) : 1'b1;
  end

  task automatic load_conf(input int ch, input int cfg);
    logic [31:0] w;
    w = pat[16 + cfg * 4];
    @(negedge clk);
    conf.src_base  = w[31:16];
    conf.dst_base  = w[15:0];
    conf.length    = pat[17 + cfg * 4][15:0];
    conf.addend    = pat[18 + cfg * 4];
    conf_valid     = '0;
    conf_valid[ch] = 1'b1;
    dst_lo[ch]     = int'(w[15:0]);
    dst_len[ch]    = int'(pat[17 + cfg * 4][15:0]);
    @(negedge clk);
    conf_valid = '0;
  endtask

  task automatic start_channels(input logic [`ACC_NUM_CH-1:0] mask);
    @(negedge clk);
    start = mask;
    @(negedge clk);
    start = '0;
    @(negedge clk); // the registered done flags have dropped by now.
  endtask

  task automatic refill_dest(input int cfg);
    int a;
    for (int i = 0; i < int'(pat[17 + cfg * 4][15:0]); i++) begin
      a      = int'(pat[16 + cfg * 4][15:0]) + i;
      mem[a] = fill_word(a);
    end
  endtask

  task automatic check_dest(input int cfg);
    int a;
    for (int i = 0; i < int'(pat[17 + cfg * 4][15:0]); i++) begin
      a = int'(pat[16 + cfg * 4][15:0]) + i;
      compare_value($sformatf("mem[%0h]", a), pat[int'(pat[19 + cfg * 4]) + i], mem[a]);
    end
  endtask

  task automatic wait_done(input int ch, input int limit);
    int n;
    n = 0;
    while (!info[16 + ch] && n < limit) begin
      @(negedge clk);
      n++;
    end
    if (!info[16 + ch]) begin
      failures++;
      $display("timeout: channel %0d did not finish within %0d cycles", ch, limit);
    end
  endtask

  task automatic wait_requests(input int tag, input int count, input int limit);
    int n;
    n = 0;
    while (reqs_seen[tag] < count && n < limit) begin
      @(negedge clk);
      n++;
    end
    if (reqs_seen[tag] < count) begin
      failures++;
      $display("timeout: channel %0d issued too few requests in %0d cycles", tag, limit);
    end
  endtask

  // waits until stale traffic of a channel has drained out of the ports.
  task automatic wait_quiet(input int tag, input int limit);
    int n;
    n = 0;
    while (!(pending_reads(tag) == 0 && cycle - last_req[tag] >= 12) && n < limit) begin
      @(negedge clk);
      n++;
    end
    if (!(pending_reads(tag) == 0 && cycle - last_req[tag] >= 12)) begin
      failures++;
      $display("timeout: requests of channel %0d did not stop within %0d cycles", tag, limit);
    end
  endtask

  initial begin
    rst_n = 1'b0;
    soft_rst = '0;
    start = '0;
    conf_valid = '0;
    conf = '0;
    rd_available = 1'b1;
    wr_available = 1'b1;
    rd_resp_valid = 1'b0;
    rd_resp_data = '0;
    rd_resp_tag = '0;
    wr_resp_valid = 1'b0;
    wr_resp_tag = '0;
    stress = 1'b0;
    for (int a = 0; a < 65536; a++) mem[a] = fill_word(a);
    $readmemh("testbench/acc_mgmt_patterns.txt", pat);
    for (int i = 0; i < 16; i++) mem[16'h0100 + i] = pat[i]; // source area.
    repeat (3) @(negedge clk);
    rst_n = 1'b1;

    repeat (6) begin
      @(negedge clk);
      compare_value("rd_req_en", 0, rd_req_en);
      compare_value("wr_req_en", 0, wr_req_en);
      compare_value("info", 32'h0000_0202, info);
    end

    load_conf(0, 0);
    refill_dest(0);
    start_channels(2'b01);
    wait_done(0, 400);
    check_dest(0);
    compare_value("info[17:16]", 2'b01, info[17:16]);

    load_conf(1, 1);
    for (int pass = 0; pass < 2; pass++) begin
      stress = (pass == 1); // the second run sees random port stalls.
      refill_dest(0);
      refill_dest(1);
      start_channels(2'b11);
      wait_done(0, 2000);
      wait_done(1, 2000);
      check_dest(0);
      check_dest(1);
    end

    refill_dest(1);
    start_channels(2'b11);
    wait_requests(0, reqs_seen[0] + 3, 200);
    @(negedge clk);
    soft_rst = 2'b01;
    @(negedge clk);
    soft_rst = '0;
    wait_quiet(0, 300);
    compare_value("info[16]", 0, info[16]);
    quiet_mark = reqs_seen[0];
    wait_done(1, 2000);
    check_dest(1);
    compare_value("requests of reset channel", quiet_mark, reqs_seen[0]);
    compare_value("info[16]", 0, info[16]);

    load_conf(0, 2);
    refill_dest(2);
    start_channels(2'b01);
    wait_done(0, 2000);
    check_dest(2);

    $display("summary: %0d value mismatches, %0d other failures", errors, failures);
    if (errors == 0 && failures == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

// ==== testbench/acc_mgmt_patterns.txt ====
// 32-bit words. @00 source words placed at word address 0100 onward.
// @10 configurations, four words each: {src_base,dst_base} length addend expected_index.
// @20 expected destination words, eight per configuration.
@00
11111111 22222222 33333333 44444444
55555555 66666666 77777777 88888888
00000001 00000002 00000003 00000004
10000000 20000000 30000000 fffffffe
@10
01000200 00000008 00001000 00000020
01080300 00000008 01000001 00000028
01040400 00000008 000000ff 00000030
@20
11112111 22223222 33334333 44445444
55556555 66667666 77778777 88889888
@28
01000002 01000003 01000004 01000005
11000001 21000001 31000001 00ffffff
@30
55555654 66666765 77777876 88888987
00000100 00000101 00000102 00000103

// ==== files.f ====
+incdir+source
source/acc_mgmt_pkg.sv
source/req_fifo.sv
source/req_arbiter.sv
source/copy_channel.sv
source/stream_accelerator.sv
source/acc_mgmt_top.sv
testbench/tb_acc_mgmt.sv

// ==== Bender.yml ====
package:
  name: acc_mgmt

sources:
  - include_dirs:
      - source
    files:
      - source/acc_mgmt_pkg.sv
      - source/req_fifo.sv
      - source/req_arbiter.sv
      - source/copy_channel.sv
      - source/stream_accelerator.sv
      - source/acc_mgmt_top.sv
  - target: simulation
    include_dirs:
      - source
    files:
      - testbench/tb_acc_mgmt.sv
